/* files.f */
hw/uartPkg.sv
hw/baudTickGen.sv
hw/uartRec.sv
hw/uartTrans.sv
hw/uartFifo.sv
hw/uartPort.sv
hw/uartPeripheral.sv
tests/tbClock.sv
tests/uartTb.sv

/* hw/baudTickGen.sv */
////////////////////////////////////////
// baud tick generator
// one-cycle tick every baudDivisor clocks,
// 16 ticks per bit on the line
////////////////////////////////////////

`timescale 1ns/1ps

module baudTickGen #(
	parameter int baudDivisor = 27	// clocks per oversampling tick
) (
	input logic clk,
	input logic reset,
	output logic sTick
);

	localparam int cntW = (baudDivisor > 1) ? $clog2(baudDivisor) : 1;

	logic [cntW-1:0] cnt;	// wraps at baudDivisor-1

	// registered tick, first one lands baudDivisor edges out of reset
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			sTick <= 1'b0;
		end
		else if (cnt == cntW'(baudDivisor - 1))
		begin
			cnt <= '0;	// terminal count
			sTick <= 1'b1;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

/* hw/uartFifo.sv */
////////////////////////////////////////
// uart fifo
// first-word-fall-through byte buffer,
// overflow pulses on a push while full
////////////////////////////////////////

`timescale 1ns/1ps

module uartFifo #(
	parameter int fifoAddrLen = 4	// depth is 2**fifoAddrLen
) (
	input logic clk,
	input logic reset,
	input logic push,
	input uartPkg::uartData_t pushData,
	input logic pop,
	output uartPkg::uartData_t head,
	output logic empty,
	output logic full,
	output logic overflow
);

	import uartPkg::*;

	localparam int depth = 2 ** fifoAddrLen;

	uartData_t mem [depth];	// storage, no reset
	logic [fifoAddrLen-1:0] wrPtr, rdPtr;
	logic [fifoAddrLen:0] count;	// one extra bit to tell full from empty
	logic doPush, doPop;

	assign doPush = push && !full;	// dropped when full
	assign doPop = pop && !empty;	// ignored when empty

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	// head valid whenever not empty
	assign head = mem[rdPtr];
	assign empty = (count == '0);
	assign full = (count == (fifoAddrLen + 1)'(depth));
	assign overflow = push && full;

endmodule

/* hw/uartPeripheral.sv */
////////////////////////////////////////
// uart peripheral top
// tick generator, rx and tx paths with
// fifos, and the processor port block
////////////////////////////////////////

`timescale 1ns/1ps

module uartPeripheral #(
	parameter int dataBits = 8,
	parameter int sbTick = 16,	// one stop bit
	parameter int fifoAddrLen = 4,	// 16 entries per fifo
	parameter int baudDivisor = 27	// 50 MHz clk, 115200 baud
) (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic tx,
	input logic rdStrobe,
	input logic wrStrobe,
	input uartPkg::uartData_t wrData,
	input logic statRead,
	output uartPkg::uartData_t rdData,
	output uartPkg::uartStat_t status
);

	import uartPkg::*;

	logic sTick;
	logic rxDoneTick, rxEmpty, rxFull, rxOverflow, rxPop;
	logic txEmpty, txFull, txPop, txBusy;
	uartData_t rxByte, rxHead, txHead;
	uartLineStat_t lineStat;

	baudTickGen #(.baudDivisor(baudDivisor)) tickGen (.clk, .reset, .sTick);

	////////////////////////////////////////
	// receive side
	////////////////////////////////////////

	uartRec #(.dataBits(dataBits), .sbTick(sbTick)) rec (
		.clk, .reset, .sTick, .rx, .rxDoneTick, .dOut(rxByte)
	);

	uartFifo #(.fifoAddrLen(fifoAddrLen)) rxFifo (
		.clk, .reset, .push(rxDoneTick), .pushData(rxByte), .pop(rxPop),
		.head(rxHead), .empty(rxEmpty), .full(rxFull), .overflow(rxOverflow)
	);

	////////////////////////////////////////
	// transmit side
	////////////////////////////////////////

	// tx overflow left open, processor polls txFull before writing
	uartFifo #(.fifoAddrLen(fifoAddrLen)) txFifo (
		.clk, .reset, .push(wrStrobe), .pushData(wrData), .pop(txPop),
		.head(txHead), .empty(txEmpty), .full(txFull), .overflow()
	);

	uartTrans #(.dataBits(dataBits), .sbTick(sbTick)) trans (
		.clk, .reset, .sTick, .txEmpty, .txHead, .txPop, .txBusy, .tx
	);

	// flags for the port block
	assign lineStat.rxEmpty = rxEmpty;
	assign lineStat.rxFull = rxFull;
	assign lineStat.txEmpty = txEmpty;
	assign lineStat.txFull = txFull;
	assign lineStat.txBusy = txBusy;
	assign lineStat.rxOverflow = rxOverflow;

	uartPort port (
		.clk, .reset, .rdStrobe, .statRead, .lineStat, .rxHead,
		.rdData, .status, .rxPop
	);

endmodule

/* hw/uartPkg.sv */
////////////////////////////////////////
// uart package
// shared data, status and line types for
// the receive, transmit and port blocks
////////////////////////////////////////

package uartPkg;

	////////////////////////////////////////
	// data and status widths
	////////////////////////////////////////

	typedef logic [7:0] uartData_t;	// one byte on the line or in a fifo
	typedef logic [7:0] uartStat_t;	// status byte seen by the processor

	// status bit positions, upper bits read zero
	localparam int rxAvailBit = 0;	// rx fifo holds data
	localparam int rxFullBit = 1;	// rx fifo full
	localparam int txFullBit = 2;	// tx fifo full
	localparam int txIdleBit = 3;	// nothing queued, nothing shifting
	localparam int overrunBit = 4;	// a received byte was dropped

	////////////////////////////////////////
	// state machines
	////////////////////////////////////////

	typedef enum logic [1:0] {
		rxIdle = 2'b00,
		rxStart = 2'b01,
		rxData = 2'b10,
		rxStop = 2'b11
	} rxState_t;

	typedef enum logic [1:0] {
		txIdle = 2'b00,
		txStart = 2'b01,
		txData = 2'b10,
		txStop = 2'b11
	} txState_t;

	// flags gathered from both sides for the port block
	typedef struct packed {
		logic rxEmpty;	// rx fifo empty
		logic rxFull;	// rx fifo full
		logic txEmpty;	// tx fifo empty
		logic txFull;	// tx fifo full, writes get dropped
		logic txBusy;	// transmitter shifting a frame
		logic rxOverflow;	// one-cycle pulse, byte lost on push
	} uartLineStat_t;

endpackage

/* hw/uartPort.sv */
////////////////////////////////////////
// uart port block
// processor read data, status byte and
// the sticky overrun flag
////////////////////////////////////////

`timescale 1ns/1ps

module uartPort (
	input logic clk,
	input logic reset,
	input logic rdStrobe,	// processor read, pops rx fifo
	input logic statRead,	// processor status read
	input uartPkg::uartLineStat_t lineStat,
	input uartPkg::uartData_t rxHead,
	output uartPkg::uartData_t rdData,
	output uartPkg::uartStat_t status,
	output logic rxPop
);

	import uartPkg::*;

	logic overrun;	// sticky, lost rx byte

	////////////////////////////////////////
	// overrun flag
	////////////////////////////////////////

	// a new loss in the same cycle as a status read keeps the flag set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			overrun <= 1'b0;
		else if (lineStat.rxOverflow)
			overrun <= 1'b1;
		else if (statRead)
			overrun <= 1'b0;	// cleared once the processor has seen it
	end

	////////////////////////////////////////
	// status byte
	////////////////////////////////////////

	always_comb
	begin
		status = '0;	// unused upper bits
		status[rxAvailBit] = !lineStat.rxEmpty;
		status[rxFullBit] = lineStat.rxFull;
		status[txFullBit] = lineStat.txFull;
		status[txIdleBit] = lineStat.txEmpty && !lineStat.txBusy;	// nothing left to send
		status[overrunBit] = overrun;
	end

	// fall-through head goes straight out
	assign rdData = rxHead;
	assign rxPop = rdStrobe;

endmodule

/* hw/uartRec.sv */
////////////////////////////////////////
// uart receiver
// 16x oversampling of rx, bytes built LSB
// first, rxDoneTick at end of the stop bit
////////////////////////////////////////

`timescale 1ns/1ps

module uartRec #(
	parameter int dataBits = 8,	// data bits per frame
	parameter int sbTick = 16	// stop length in ticks
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDoneTick,
	output uartPkg::uartData_t dOut
);

	import uartPkg::*;

	localparam int tickW = (sbTick > 16) ? $clog2(sbTick) : 4;	// must reach 15 for data bits
	localparam int nW = (dataBits > 1) ? $clog2(dataBits) : 1;
	localparam int byteW = $bits(uartData_t);

	rxState_t stateReg, stateNext;
	logic [tickW-1:0] sReg, sNext;	// tick counter within a bit
	logic [nW-1:0] nReg, nNext;	// data bit counter
	uartData_t bReg, bNext;	// shift register

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= rxIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	// payload, no reset
	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////////////////////////
	// next state
	////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			rxIdle:
				if (!rx)
				begin
					stateNext = rxStart;	// falling edge, start bit begins
					sNext = '0;
				end
			rxStart:
				if (sTick)
				begin
					if (sReg == tickW'(7))
					begin
						stateNext = rxData;	// mid start bit, align to bit centres
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxData:
				if (sTick)
				begin
					if (sReg == tickW'(15))
					begin
						sNext = '0;
						bNext = {rx, bReg[byteW-1:1]};	// lsb arrives first
						if (nReg == nW'(dataBits - 1))
							stateNext = rxStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			rxStop:
				if (sTick)
				begin
					if (sReg == tickW'(sbTick - 1))
					begin
						stateNext = rxIdle;
						rxDoneTick = 1'b1;	// byte in bReg is complete
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = rxIdle;
		endcase
	end

	assign dOut = bReg;

endmodule

/* hw/uartTrans.sv */
////////////////////////////////////////
// uart transmitter
// pops the tx fifo and sends start bit,
// data LSB first and a high stop bit
////////////////////////////////////////

`timescale 1ns/1ps

module uartTrans #(
	parameter int dataBits = 8,	// data bits per frame
	parameter int sbTick = 16	// stop length in ticks
) (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txEmpty,
	input uartPkg::uartData_t txHead,
	output logic txPop,
	output logic txBusy,
	output logic tx
);

	import uartPkg::*;

	localparam int tickW = (sbTick > 16) ? $clog2(sbTick) : 4;
	localparam int nW = (dataBits > 1) ? $clog2(dataBits) : 1;

	txState_t stateReg, stateNext;
	logic [tickW-1:0] sReg, sNext;	// ticks within the current bit
	logic [nW-1:0] nReg, nNext;	// bits sent so far
	uartData_t bReg, bNext;	// outgoing shift register
	logic txReg, txNext;	// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txPop = 1'b0;

		case (stateReg)
			txIdle:
			begin
				txNext = 1'b1;
				if (sTick && !txEmpty)	// start on a tick so the bit is full length
				begin
					stateNext = txStart;
					sNext = '0;
					bNext = txHead;
					txPop = 1'b1;	// head consumed
					txNext = 1'b0;	// start bit
				end
			end
			txStart:
				if (sTick)
				begin
					if (sReg == tickW'(15))
					begin
						stateNext = txData;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];	// first data bit
					end
					else
						sNext = sReg + 1'b1;
				end
			txData:
				if (sTick)
				begin
					if (sReg == tickW'(15))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == nW'(dataBits - 1))
						begin
							stateNext = txStop;
							txNext = 1'b1;	// stop bit
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];	// next bit after shift
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			txStop:
				if (sTick)
				begin
					if (sReg == tickW'(sbTick - 1))
						stateNext = txIdle;
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = txIdle;
		endcase
	end

	assign txBusy = (stateReg != txIdle);
	assign tx = txReg;

endmodule

/* tests/tbClock.sv */
////////////////////////////////////////
// testbench clock and reset
// free-running clock, reset held for a
// few rising edges after time zero
////////////////////////////////////////

`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs = 40,	// clock period
	parameter int resetCycles = 4	// edges with reset high
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;	// asynchronous, active high
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;	// released on an edge like the other inputs
	end

endmodule

/* tests/uartStimulus.txt */
// records in hex: op, byte count, gap in clocks, then the bytes
// op 1 rx single, 2 rx burst, 3 tx single, 4 tx burst, 5 rx bytes then tx bytes, 00 ends
01 04 10
55 A5 00 FF
02 11 00
11 22 33 44 55 66 77 88
99 AA BB CC DD EE F0 0F
E7
03 03 08
3C C3 81
04 11 00
01 02 04 08 10 20 40 80
FE FD FB F7 EF DF BF 7F
5A
05 06 04
12 34 56 78 9A BC
DE AD BE EF 0D F0
00

/* tests/uartTb.sv */
////////////////////////////////////////
// uart peripheral testbench
// replays stimulus records on rx and the
// strobes, decodes tx and checks results
////////////////////////////////////////

`timescale 1ns/1ps

module uartTb;

	import uartPkg::*;

	localparam int baudDiv = 4;	// clocks per tick
	localparam int bitClks = 16 * baudDiv;	// 64 clocks per bit
	localparam int halfBit = bitClks / 2;
	localparam int fifoDepth = 16;
	localparam int waitLimit = 2000;	// cycles, a bit over three frames

	logic clk, reset;
	logic rx, tx, rdStrobe, wrStrobe, statRead;
	uartData_t wrData, rdData;
	uartStat_t status;

	logic [7:0] stim [256];	// stimulus records, see the data file
	uartData_t txGot [$];	// bytes decoded from tx
	logic [7:0] lfsrState = 8'd8;
	int rxGap [64], txGap [64];
	int errors = 0, checks = 0, testCount = 0;
	longint limitNs;
	logic limitReady = 1'b0;

	tbClock #(.periodNs(40), .resetCycles(4)) clkGen (.clk, .reset);

	uartPeripheral #(.baudDivisor(baudDiv)) dut (
		.clk, .reset, .rx, .tx, .rdStrobe, .wrStrobe, .wrData,
		.statRead, .rdData, .status
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// galois form, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	task automatic randomBits(input int width, output int val);
		val = 0;
		for (int i = 0; i < width; i++)
		begin
			lfsrState = lfsrNext(lfsrState);	// one step per bit
			val = (val << 1) | lfsrState[0];
		end
	endtask

	task automatic compareByte(input uartData_t got, input uartData_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// polls at negedge where the combinational status has settled
	task automatic waitStatus(input int bitIdx, input logic val);
		int waited;
		waited = 0;
		@(negedge clk);
		while (status[bitIdx] !== val && waited < waitLimit)
		begin
			@(negedge clk);
			waited++;
		end
		if (status[bitIdx] !== val)
		begin
			$display("timeout at %0t: status bit %0d never became %0b", $time, bitIdx, val);
			errors++;
		end
	endtask

	task automatic waitTxCount(input int n);
		int waited;
		waited = 0;
		while (txGot.size() < n && waited < (n + 2) * 800)
		begin
			@(negedge clk);
			waited++;
		end
		if (txGot.size() < n)
		begin
			$display("timeout at %0t: only %0d of %0d bytes seen on tx", $time, txGot.size(), n);
			errors++;
		end
	endtask

	// bit-bang one frame, start, LSB first, stop
	task automatic sendRx(input uartData_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk) rx <= frame[i];
			repeat (bitClks - 1) @(posedge clk);
		end
	endtask

	task automatic readByte(input uartData_t exp);
		waitStatus(rxAvailBit, 1'b1);
		compareByte(rdData, exp, "rdData");
		@(posedge clk) rdStrobe <= 1'b1;	// pops at the next edge
		@(posedge clk) rdStrobe <= 1'b0;
	endtask

	task automatic writeByte(input uartData_t b);
		waitStatus(txFullBit, 1'b0);	// processor side has to watch txFull
		@(posedge clk)
		begin
			wrStrobe <= 1'b1;
			wrData <= b;
		end
		@(posedge clk) wrStrobe <= 1'b0;
	endtask

	////////////////////////////////////////
	// tests, one per record op
	////////////////////////////////////////

	task automatic receiveSingles(input int base, input int n, input int gap);
		int extra;
		for (int i = 0; i < n; i++)
		begin
			sendRx(stim[base + i]);
			readByte(stim[base + i]);
			@(negedge clk);
			checks++;
			if (status[rxAvailBit] !== 1'b0)
			begin
				$display("Mismatch at %0t: rxAvail still set after read", $time);
				errors++;
			end
			randomBits(5, extra);
			repeat (gap + extra) @(posedge clk);
		end
	endtask

	// fills the rx fifo, loses the last byte, then clears overrun
	task automatic receiveBurst(input int base, input int n);
		uartStat_t expStat;
		expStat = '0;
		expStat[rxAvailBit] = 1'b1;
		expStat[rxFullBit] = 1'b1;
		expStat[txIdleBit] = 1'b1;	// tx side untouched
		expStat[overrunBit] = 1'b1;	// last byte found the fifo full
		for (int i = 0; i < n; i++)
			sendRx(stim[base + i]);	// no reads in between
		waitStatus(overrunBit, 1'b1);
		@(negedge clk);
		compareByte(status, expStat, "status after burst");
		@(posedge clk) statRead <= 1'b1;
		@(posedge clk) statRead <= 1'b0;	// overrun drops at this edge
		@(negedge clk);
		expStat[overrunBit] = 1'b0;
		compareByte(status, expStat, "status after statRead");
		for (int i = 0; i < fifoDepth; i++)
			readByte(stim[base + i]);
		@(negedge clk);
		compareByte(status, 8'h08, "status after draining rx");
	endtask

	task automatic transmitSingles(input int base, input int n, input int gap);
		for (int i = 0; i < n; i++)
		begin
			txGot.delete();
			writeByte(stim[base + i]);
			waitTxCount(1);
			if (txGot.size() > 0)
				compareByte(txGot[0], stim[base + i], "tx byte");
			waitStatus(txIdleBit, 1'b1);
			repeat (gap) @(posedge clk);
		end
	endtask

	// transmitter takes the first byte, so n = depth + 1 fills the fifo
	task automatic transmitBurst(input int base, input int n);
		txGot.delete();
		for (int i = 0; i < n; i++)
		begin
			@(posedge clk)
			begin
				wrStrobe <= 1'b1;
				wrData <= stim[base + i];
			end
		end
		@(posedge clk) wrStrobe <= 1'b0;
		@(negedge clk);
		checks++;
		if (status[txFullBit] !== 1'b1)
		begin
			$display("Mismatch at %0t: txFull not set after burst", $time);
			errors++;
		end
		waitTxCount(n);
		for (int i = 0; i < txGot.size() && i < n; i++)
			compareByte(txGot[i], stim[base + i], "tx burst byte");
		waitStatus(txIdleBit, 1'b1);
	endtask

	task automatic bothSides(input int base, input int n, input int gap);
		int extra;
		// gaps drawn up front so the streams never race on the lfsr
		for (int i = 0; i < n; i++)
		begin
			randomBits(5, extra);
			rxGap[i] = gap + extra;
			randomBits(5, extra);
			txGap[i] = gap + extra;
		end
		txGot.delete();
		fork
			for (int i = 0; i < n; i++)
			begin
				sendRx(stim[base + i]);
				repeat (rxGap[i]) @(posedge clk);
			end
			for (int i = 0; i < n; i++)
			begin
				repeat (txGap[i]) @(posedge clk);
				writeByte(stim[base + n + i]);
			end
			for (int i = 0; i < n; i++)
				readByte(stim[base + i]);	// reader keeps up with rx
		join
		waitTxCount(n);
		for (int i = 0; i < txGot.size() && i < n; i++)
			compareByte(txGot[i], stim[base + n + i], "tx stream byte");
		waitStatus(txIdleBit, 1'b1);
	endtask

	function automatic string testName(input int op);
		case (op)
			1: return "rx single";
			2: return "rx burst, overrun and clear";
			3: return "tx single";
			4: return "tx burst";
			5: return "rx and tx together";
			default: return "unknown op";
		endcase
	endfunction

	////////////////////////////////////////
	// tx line decoder, samples mid-bit
	////////////////////////////////////////

	initial
	begin : txDecoder
		uartData_t b;
		@(negedge reset);
		forever
		begin
			@(negedge tx);
			repeat (halfBit) @(negedge clk);
			if (tx !== 1'b0)
			begin
				$display("Mismatch at %0t: tx start bit not low at mid-bit", $time);
				errors++;
			end
			for (int i = 0; i < 8; i++)
			begin
				repeat (bitClks) @(negedge clk);
				b[i] = tx;	// lsb first
			end
			repeat (bitClks) @(negedge clk);
			if (tx !== 1'b1)
			begin
				$display("Mismatch at %0t: tx stop bit low", $time);
				errors++;
			end
			txGot.push_back(b);
		end
	end

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial
	begin : mainSeq
		int p, op, n, gap, base, errBefore, frames, gapSum;
		rx = 1'b1;	// line idles high
		rdStrobe = 1'b0;
		wrStrobe = 1'b0;
		wrData = '0;
		statRead = 1'b0;
		$readmemh("tests/uartStimulus.txt", stim);

		// frame count sets the watchdog, 640 clocks per frame plus gaps
		frames = 0;
		gapSum = 0;
		p = 0;
		while (stim[p] !== 8'h00 && !$isunknown(stim[p]))
		begin
			n = (stim[p] == 8'h05) ? 2 * stim[p + 1] : stim[p + 1];
			frames += n;
			gapSum += n * (stim[p + 2] + 32);
			p += 3 + n;
		end
		limitNs = 64'(2 * (frames * 160 * baudDiv + gapSum) + 5000) * 40;
		limitReady = 1'b1;

		@(negedge reset);
		@(negedge clk);
		compareByte(status, 8'h08, "status after reset");	// only txIdle
		testCount++;
		$display("test %0d (reset state): %0d errors", testCount, errors);

		p = 0;
		while (stim[p] !== 8'h00 && !$isunknown(stim[p]))
		begin
			op = stim[p];
			n = stim[p + 1];
			gap = stim[p + 2];
			base = p + 3;
			errBefore = errors;
			case (op)
				1: receiveSingles(base, n, gap);
				2: receiveBurst(base, n);
				3: transmitSingles(base, n, gap);
				4: transmitBurst(base, n);
				5: bothSides(base, n, gap);
				default:
				begin
					$display("stimulus record at word %0d has unknown op %0d", p, op);
					errors++;
				end
			endcase
			p = base + ((op == 5) ? 2 * n : n);
			testCount++;
			$display("test %0d (%s): %0d errors", testCount, testName(op), errors - errBefore);
		end

		$display("tests %0d, checks %0d, errors %0d", testCount, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		wait (limitReady);
		#(limitNs);
		$display("watchdog expired at %0t, run did not finish in time", $time);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
